/* vlog.f */
+incdir+include
hdl/vga_sram_pkg.sv
hdl/sram_port_switch.sv
hdl/sram_read_capture.sv
hdl/pixel_color_map.sv
hdl/vga_sram_top.sv
tb/tb_clock_gen.sv
tb/tb_checker.sv
tb/tb_vga_sram.sv

/* Bender.yml */
package:
  name: vga_sram

sources:
  - include_dirs:
      - include
    files:
      - hdl/vga_sram_pkg.sv
      - hdl/sram_port_switch.sv
      - hdl/sram_read_capture.sv
      - hdl/pixel_color_map.sv
      - hdl/vga_sram_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - tb/tb_clock_gen.sv
      - tb/tb_checker.sv
      - tb/tb_vga_sram.sv

/* tb/tb_vga_sram.sv */
// Testbench top for the video SRAM path
// SRAM model, reference memory, stimulus table and its loop, timeout

`timescale 1ns/1ps
`include "vga_sram_cfg.svh"

module tb_vga_sram
   import vga_sram_pkg::*;
();

   localparam int NUM_STEPS = 10;
   localparam int LIMIT     = NUM_STEPS * 40 + 100;
   localparam int MEM_WORDS = 1 << `VS_ADDR_W;

   // Step kinds
   localparam logic [1:0] K_VIDEO = 2'd0;
   localparam logic [1:0] K_READ  = 2'd1;
   localparam logic [1:0] K_WRITE = 2'd2;
   localparam logic [1:0] K_PRIO  = 2'd3;

   typedef struct packed {
      logic [1:0]            kind;
      logic [1:0]            id;        // Requester
      logic [9:0]            x;
      logic [9:0]            y;
      logic [`VS_ADDR_W-1:0] addr;      // Read address
      logic                  byte_hi;
      logic [15:0]           wdata;
      logic [11:0]           order;     // Expected grant ids with the first in the low bits
   } step_t;

   logic                    clk;
   logic                    reset;
   logic [`VS_COORD_W-1:0]  pix_x;
   logic [`VS_COORD_W-1:0]  pix_y;
   sram_req_t               req [`VS_NUM_REQ];
   logic [`VS_NUM_REQ-1:0]  grant;
   logic [`VS_DATA_W-1:0]   rd_data [`VS_NUM_REQ];
   logic [`VS_NUM_REQ-1:0]  rd_valid;
   sram_bus_t               sram;
   logic [`VS_DATA_W-1:0]   sram_dq_in;
   logic [`VS_RGB_W-1:0]    pix_r;
   logic [`VS_RGB_W-1:0]    pix_g;
   logic [`VS_RGB_W-1:0]    pix_b;
   logic                    pix_valid;

   logic [15:0] sram_mem [MEM_WORDS];   // SRAM model
   logic [15:0] ref_mem  [MEM_WORDS];   // Expected contents
   step_t       steps    [NUM_STEPS];
   logic        tb_phase;               // 0 = next edge sets up video
   int          cycles = 0;

   tb_clock_gen u_clk (.clk(clk), .reset(reset));

   vga_sram_top u_dut (
      .clk        (clk),
      .reset      (reset),
      .pix_x      (pix_x),
      .pix_y      (pix_y),
      .req        (req),
      .grant      (grant),
      .rd_data    (rd_data),
      .rd_valid   (rd_valid),
      .sram       (sram),
      .sram_dq_in (sram_dq_in),
      .pix_r      (pix_r),
      .pix_g      (pix_g),
      .pix_b      (pix_b),
      .pix_valid  (pix_valid)
   );

   tb_checker u_chk (.clk(clk), .reset(reset), .grant(grant), .sram(sram));

   //////////////////////////////////////////////////
   // SRAM model and phase tracking
   //////////////////////////////////////////////////
   assign sram_dq_in = sram_mem[sram.addr];   // Asynchronous read

   always @(posedge clk)
   begin
      if (!sram.we_n)
      begin
         if (!sram.lb_n)
            sram_mem[sram.addr][7:0] <= sram.dq_out[7:0];
         if (!sram.ub_n)
            sram_mem[sram.addr][15:8] <= sram.dq_out[15:8];
      end
   end

   always @(posedge clk or negedge reset)
   begin
      if (!reset)
         tb_phase <= 1'b0;
      else
         tb_phase <= ~tb_phase;   // Video and processor alternate
   end

   // Run limit from the table length
   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= LIMIT)
      begin
         $display("Run stopped after %0d cycles without finishing the table", cycles);
         $display("Testbench failed");
         $finish;
      end
   end

   //////////////////////////////////////////////////
   // Expected value helpers
   //////////////////////////////////////////////////
   function automatic logic [`VS_ADDR_W-1:0] word_addr(input logic [9:0] x,
                                                       input logic [9:0] y);
      return {y[8:0], x[9:1]};   // Two pixels per word
   endfunction

   // Component value for a 2-bit field at a brightness level
   function automatic logic [9:0] comp_val(input logic [1:0] f, input logic [1:0] lvl);
      int full;
      full = (f == 2'd0) ? `VS_RAMP_0 : (f == 2'd1) ? `VS_RAMP_1 :
             (f == 2'd2) ? `VS_RAMP_2 : `VS_RAMP_3;
      return 10'(full / (1 << (3 - lvl)));
   endfunction

   // Expected {r, g, b} of a pixel from its word
   function automatic logic [29:0] exp_rgb(input logic [15:0] w, input logic odd);
      logic [7:0] b;
      b = odd ? w[15:8] : w[7:0];
      return {comp_val(b[5:4], b[7:6]), comp_val(b[3:2], b[7:6]),
              comp_val(b[1:0], b[7:6])};
   endfunction

   //////////////////////////////////////////////////
   // Step tasks
   //////////////////////////////////////////////////
   task automatic check_idle_outputs();
      u_chk.check_val("grant", 0, grant);
      u_chk.check_val("rd_valid", 0, rd_valid);
      u_chk.check_val("pix_valid", 0, pix_valid);
      u_chk.check_val("sram.we_n", 1, sram.we_n);
      u_chk.check_val("sram.dq_oe", 0, sram.dq_oe);
   endtask

   task automatic video_read(input logic [9:0] x, input logic [9:0] y);
      logic [29:0] exp;
      @(negedge clk);
      while (tb_phase != 1'b1)
         @(negedge clk);
      @(posedge clk);               // Processor edge so the video edge follows
      pix_x <= x;
      pix_y <= y;
      repeat (3) @(posedge clk);    // Setup, capture, colour register
      @(negedge clk);
      exp = exp_rgb(ref_mem[word_addr(x, y)], x[0]);
      u_chk.check_val("pix_valid", 1, pix_valid);
      u_chk.check_val("pix_r", exp[29:20], pix_r);
      u_chk.check_val("pix_g", exp[19:10], pix_g);
      u_chk.check_val("pix_b", exp[9:0], pix_b);
   endtask

   task automatic req_access(input int id, input logic wr, input logic hi,
                             input logic [`VS_ADDR_W-1:0] addr, input logic [15:0] wdata);
      int waited;
      waited = 0;
      @(posedge clk);
      req[id] <= '{req: 1'b1, write: wr, byte_hi: hi, addr: addr, wdata: wdata};
      do
      begin
         @(negedge clk);
         waited++;
      end
      while (!grant[id] && waited < 60);
      if (!grant[id])
      begin
         u_chk.check_true(1'b0, "requester was never granted the SRAM");
         return;
      end
      u_chk.check_val("grant on processor cycle", 0, tb_phase);
      @(posedge clk);
      req[id].req <= 1'b0;          // Hold counter blocks a second grant
      if (wr)
      begin
         if (hi)
            ref_mem[addr][15:8] = wdata[15:8];
         else
            ref_mem[addr][7:0] = wdata[7:0];
      end
      @(negedge clk);
      if (!wr)
      begin
         u_chk.check_val("rd_valid", 1 << id, rd_valid);
         u_chk.check_val("rd_data", ref_mem[addr], rd_data[id]);
      end
   endtask

   // All three raised together and held while grants are logged
   task automatic priority_hold(input logic [11:0] order);
      int ids [$];
      int at  [$];
      int n;
      repeat (2 * `VS_HOLD_CYCLES + 4) @(posedge clk);   // Let lockouts clear
      for (int i = 0; i < `VS_NUM_REQ; i++)
         req[i] <= '{req: 1'b1, write: 1'b0, byte_hi: 1'b0,
                     addr: 18'h00040 + i, wdata: 16'h0};
      n = 0;
      while (ids.size() < 6 && n < 40)
      begin
         @(negedge clk);
         n++;
         if (grant != '0)
         begin
            u_chk.check_val("grant on processor cycle", 0, tb_phase);
            for (int i = 0; i < `VS_NUM_REQ; i++)
               if (grant[i])
               begin
                  ids.push_back(i);
                  at.push_back(n);
               end
         end
      end
      @(posedge clk);
      for (int i = 0; i < `VS_NUM_REQ; i++)
         req[i].req <= 1'b0;
      u_chk.check_val("grant count", 6, ids.size());
      for (int k = 0; k < ids.size() && k < 6; k++)
         u_chk.check_val("grant id", order[2*k +: 2], ids[k]);
      if (ids.size() >= 3)
         u_chk.check_val("cycles between first grants", 2, at[1] - at[0]);
      for (int k = 3; k < ids.size(); k++)
         u_chk.check_true(at[k] - at[k-3] >= 12, "requester granted again inside its hold");
   endtask

   //////////////////////////////////////////////////
   // Stimulus table and run
   //////////////////////////////////////////////////
   initial
   begin
      void'($urandom(32'h3000));   // One seed for the run
      pix_x = '0;
      pix_y = '0;
      for (int i = 0; i < `VS_NUM_REQ; i++)
         req[i] = '0;
      for (int a = 0; a < MEM_WORDS; a++)
      begin
         sram_mem[a] = 16'($urandom);
         ref_mem[a]  = sram_mem[a];
      end

      //          kind     id    x       y      addr         hi    wdata     order
      steps[0] = '{K_VIDEO, 2'd0, 10'd5,   10'd3,  18'h0,       1'b0, 16'h0,    12'h0};
      steps[1] = '{K_VIDEO, 2'd0, 10'd6,   10'd3,  18'h0,       1'b0, 16'h0,    12'h0};
      steps[2] = '{K_READ,  2'd0, 10'd0,   10'd0,  18'h00123,   1'b0, 16'h0,    12'h0};
      steps[3] = '{K_READ,  2'd2, 10'd0,   10'd0,  18'h3ffff,   1'b0, 16'h0,    12'h0};
      steps[4] = '{K_WRITE, 2'd1, 10'd100, 10'd7,  18'h0,       1'b1, 16'hc3a5, 12'h0};
      steps[5] = '{K_VIDEO, 2'd0, 10'd101, 10'd7,  18'h0,       1'b0, 16'h0,    12'h0};
      steps[6] = '{K_VIDEO, 2'd0, 10'd100, 10'd7,  18'h0,       1'b0, 16'h0,    12'h0};
      steps[7] = '{K_WRITE, 2'd0, 10'd200, 10'd20, 18'h0,       1'b0, 16'h5a7e, 12'h0};
      steps[8] = '{K_VIDEO, 2'd0, 10'd200, 10'd20, 18'h0,       1'b0, 16'h0,    12'h0};
      steps[9] = '{K_PRIO,  2'd0, 10'd0,   10'd0,  18'h0,       1'b0, 16'h0,
                   {2'd2, 2'd1, 2'd0, 2'd2, 2'd1, 2'd0}};   // 1,2,3 then again

      // Reset state during reset and after the first active edge
      repeat (3) @(negedge clk);
      check_idle_outputs();
      wait (reset);
      @(posedge clk);
      @(negedge clk);
      check_idle_outputs();
      u_chk.step_done(-1, "reset state");

      for (int s = 0; s < NUM_STEPS; s++)
      begin
         case (steps[s].kind)
            K_VIDEO:
            begin
               video_read(steps[s].x, steps[s].y);
               u_chk.step_done(s, "video read");
            end
            K_READ:
            begin
               req_access(steps[s].id, 1'b0, 1'b0, steps[s].addr, 16'h0);
               u_chk.step_done(s, "requester read");
            end
            K_WRITE:
            begin
               req_access(steps[s].id, 1'b1, steps[s].byte_hi,
                          word_addr(steps[s].x, steps[s].y), steps[s].wdata);
               u_chk.step_done(s, "byte write");
            end
            default:
            begin
               priority_hold(steps[s].order);
               u_chk.step_done(s, "priority and hold");
            end
         endcase
      end

      u_chk.report();
      if (u_chk.errors == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule

/* tb/tb_checker.sv */
// Testbench checker for the video SRAM path
// Value compares, per-step result lines, bus watchers, closing counts

`timescale 1ns/1ps
`include "vga_sram_cfg.svh"

module tb_checker
   import vga_sram_pkg::*;
(
   input  logic                    clk,
   input  logic                    reset,
   input  logic [`VS_NUM_REQ-1:0]  grant,
   input  sram_bus_t               sram
);

   int errors = 0;
   int checks = 0;
   int steps  = 0;
   int step_errors = 0;   // Errors seen when the current step began

   // Compare one value, report a mismatch at once
   task automatic check_val(input string name, input logic [31:0] exp,
                            input logic [31:0] act);
      checks++;
      if (exp !== act)
      begin
         errors++;
         $display("ERROR at %0t ns: %s expected %0h, got %0h", $time, name, exp, act);
      end
   endtask

   // Failure that is not a wrong value
   task automatic check_true(input logic cond, input string what);
      checks++;
      if (!cond)
      begin
         errors++;
         $display("At %0t ns: %s", $time, what);
      end
   endtask

   // One line per finished step
   task automatic step_done(input int idx, input string what);
      steps++;
      if (errors == step_errors)
         $display("step %0d %-24s ok", idx, what);
      else
         $display("step %0d %-24s %0d mismatches", idx, what, errors - step_errors);
      step_errors = errors;
   endtask

   task automatic report();
      $display("%0d steps, %0d checks, %0d errors", steps, checks, errors);
   endtask

   //////////////////////////////////////////////////
   // Continuous watchers
   //////////////////////////////////////////////////
   always @(negedge clk)
   begin
      if (reset)
      begin
         if (!$onehot0(grant))
            check_true(1'b0, "more than one requester granted in the same cycle");
         if (!sram.we_n && !sram.dq_oe)
            check_true(1'b0, "SRAM write strobe low while data bus not driven");
         if (!sram.we_n && (sram.lb_n == sram.ub_n))
            check_true(1'b0, "SRAM write does not select exactly one byte");
      end
   end

endmodule

/* tb/tb_clock_gen.sv */
// Testbench clock and reset source
// 4 ns clock, active-low reset held for 10 cycles

`timescale 1ns/1ps

module tb_clock_gen
(
   output logic clk,
   output logic reset
);

   initial
   begin
      clk   = 1'b0;
      reset = 1'b0;        // Held from time zero
   end

   always #2 clk = ~clk;   // 4 ns period

   initial
   begin
      repeat (10) @(posedge clk);
      reset <= 1'b1;       // Released on an edge
   end

endmodule

/* hdl/vga_sram_top.sv */
// Video SRAM path top level
// Port switch, read capture and colour map in a three stage pipeline

`timescale 1ns/1ps
`include "vga_sram_cfg.svh"

module vga_sram_top
   import vga_sram_pkg::*;
(
   input  logic                    clk,
   input  logic                    reset,
   input  logic [`VS_COORD_W-1:0]  pix_x,        // Held two cycles per pixel
   input  logic [`VS_COORD_W-1:0]  pix_y,
   input  sram_req_t               req [`VS_NUM_REQ],
   output logic [`VS_NUM_REQ-1:0]  grant,
   output logic [`VS_DATA_W-1:0]   rd_data [`VS_NUM_REQ],
   output logic [`VS_NUM_REQ-1:0]  rd_valid,
   output sram_bus_t               sram,
   input  logic [`VS_DATA_W-1:0]   sram_dq_in,
   output logic [`VS_RGB_W-1:0]    pix_r,
   output logic [`VS_RGB_W-1:0]    pix_g,
   output logic [`VS_RGB_W-1:0]    pix_b,
   output logic                    pix_valid
);

   cap_tag_t   tag;        // Stage 1 to 2
   sram_word_u vid_word;   // Stage 2 to 3
   logic       vid_x_lsb;
   logic       vid_valid;

   sram_port_switch u_switch (
      .clk        (clk),
      .reset      (reset),
      .pix_x      (pix_x),
      .pix_y      (pix_y),
      .req        (req),
      .sram       (sram),
      .grant      (grant),
      .tag        (tag)
   );

   sram_read_capture u_capture (
      .clk        (clk),
      .reset      (reset),
      .tag        (tag),
      .sram_dq_in (sram_dq_in),
      .rd_data    (rd_data),
      .rd_valid   (rd_valid),
      .vid_word   (vid_word),
      .vid_x_lsb  (vid_x_lsb),
      .vid_valid  (vid_valid)
   );

   pixel_color_map u_color_map (
      .clk        (clk),
      .reset      (reset),
      .vid_word   (vid_word),
      .vid_x_lsb  (vid_x_lsb),
      .vid_valid  (vid_valid),
      .pix_r      (pix_r),
      .pix_g      (pix_g),
      .pix_b      (pix_b),
      .pix_valid  (pix_valid)
   );

endmodule

/* hdl/pixel_color_map.sv */
// Stage 3 of the video SRAM path
// Pixel byte select and ramp colour map to registered 10-bit RGB

`timescale 1ns/1ps
`include "vga_sram_cfg.svh"

module pixel_color_map
   import vga_sram_pkg::*;
(
   input  logic                  clk,
   input  logic                  reset,
   input  sram_word_u            vid_word,
   input  logic                  vid_x_lsb,
   input  logic                  vid_valid,
   output logic [`VS_RGB_W-1:0]  pix_r,
   output logic [`VS_RGB_W-1:0]  pix_g,
   output logic [`VS_RGB_W-1:0]  pix_b,
   output logic                  pix_valid
);

   color_index_t index;

   // Ramp value for a 2-bit field, dimmed by brightness level
   function automatic logic [`VS_RGB_W-1:0] ramp(input logic [1:0] sel,
                                                 input logic [1:0] level);
      logic [`VS_RGB_W-1:0] full;
      case (sel)
         2'd0:    full = `VS_RGB_W'(`VS_RAMP_0);
         2'd1:    full = `VS_RGB_W'(`VS_RAMP_1);
         2'd2:    full = `VS_RGB_W'(`VS_RAMP_2);
         default: full = `VS_RGB_W'(`VS_RAMP_3);
      endcase
      return full >> (2'd3 - level);   // Level 3 unshifted, level 0 by 3
   endfunction

   // Odd x sits in the upper byte
   assign index = vid_x_lsb ? vid_word.pix.hi : vid_word.pix.lo;

   //////////////////////////////////////////////////
   // Output registers
   //////////////////////////////////////////////////
   always_ff @(posedge clk or negedge reset)
   begin
      if (!reset)
         pix_valid <= 1'b0;
      else
         pix_valid <= vid_valid;   // One in every two cycles
   end

   // Colour only moves on a fresh video word
   always_ff @(posedge clk)
   begin
      if (vid_valid)
      begin
         pix_r <= ramp(index.red,   index.level);
         pix_g <= ramp(index.green, index.level);
         pix_b <= ramp(index.blue,  index.level);
      end
   end

endmodule

/* hdl/sram_read_capture.sv */
// Stage 2 of the video SRAM path
// Latches SRAM read data into requester registers or the video word,
// with the matching valid pulse

`timescale 1ns/1ps
`include "vga_sram_cfg.svh"

module sram_read_capture
   import vga_sram_pkg::*;
(
   input  logic                    clk,
   input  logic                    reset,
   input  cap_tag_t                tag,
   input  logic [`VS_DATA_W-1:0]   sram_dq_in,
   output logic [`VS_DATA_W-1:0]   rd_data [`VS_NUM_REQ],
   output logic [`VS_NUM_REQ-1:0]  rd_valid,
   output sram_word_u              vid_word,
   output logic                    vid_x_lsb,
   output logic                    vid_valid
);

   //////////////////////////////////////////////////
   // Valid pulses
   //////////////////////////////////////////////////
   always_ff @(posedge clk or negedge reset)
   begin
      if (!reset)
      begin
         rd_valid  <= '0;
         vid_valid <= 1'b0;
      end
      else
      begin
         vid_valid <= tag.vid;
         for (int i = 0; i < `VS_NUM_REQ; i++)
            rd_valid[i] <= tag.rd && (tag.req_id == 2'(i));
      end
   end

   //////////////////////////////////////////////////
   // Data registers
   //////////////////////////////////////////////////
   // SRAM answers within the setup cycle, sample at its end
   always_ff @(posedge clk)
   begin
      if (tag.vid)
      begin
         vid_word.raw <= sram_dq_in;
         vid_x_lsb    <= tag.x_lsb;   // Travels with its word
      end
      if (tag.rd)
         rd_data[tag.req_id] <= sram_dq_in;   // Held until next read
   end

   // Video and processor setups alternate, so captures never overlap
   a_valid_excl: assert property (@(posedge clk) disable iff (!reset)
      !((|rd_valid) && vid_valid));

endmodule

/* hdl/sram_port_switch.sv */
// Stage 1 of the video SRAM path
// Phase toggle, video/processor interleave, fixed priority with hold
// counters, registered SRAM bus, grant pulses and capture tag

`timescale 1ns/1ps
`include "vga_sram_cfg.svh"

module sram_port_switch
   import vga_sram_pkg::*;
(
   input  logic                    clk,
   input  logic                    reset,
   input  logic [`VS_COORD_W-1:0]  pix_x,
   input  logic [`VS_COORD_W-1:0]  pix_y,
   input  sram_req_t               req [`VS_NUM_REQ],
   output sram_bus_t               sram,
   output logic [`VS_NUM_REQ-1:0]  grant,
   output cap_tag_t                tag
);

   localparam int HOLD_W = $clog2(`VS_HOLD_CYCLES + 1);

   logic                    phase;        // 0 = video setup, 1 = processor setup
   logic [HOLD_W-1:0]       hold [`VS_NUM_REQ];
   logic [`VS_NUM_REQ-1:0]  eligible;
   logic [`VS_NUM_REQ-1:0]  grant_nxt;
   logic [1:0]              sel_id;
   sram_req_t               sel_req;

   //////////////////////////////////////////////////
   // Requester selection
   //////////////////////////////////////////////////
   always_comb
   begin
      for (int i = 0; i < `VS_NUM_REQ; i++)
         eligible[i] = req[i].req && (hold[i] == '0);
   end

   // Walk down so the lowest index wins
   always_comb
   begin
      grant_nxt = '0;
      sel_id    = '0;
      for (int i = `VS_NUM_REQ - 1; i >= 0; i--)
      begin
         if (phase && eligible[i])
         begin
            grant_nxt    = '0;
            grant_nxt[i] = 1'b1;
            sel_id       = 2'(i);
         end
      end
   end

   assign sel_req = req[sel_id];

   //////////////////////////////////////////////////
   // Phase, hold counters, bus register
   //////////////////////////////////////////////////
   always_ff @(posedge clk or negedge reset)
   begin
      if (!reset)
      begin
         phase <= 1'b0;
         grant <= '0;
         tag   <= '0;
         sram  <= '{addr: '0, we_n: 1'b1, lb_n: 1'b0, ub_n: 1'b0,
                    dq_oe: 1'b0, dq_out: '0};
         for (int i = 0; i < `VS_NUM_REQ; i++)
            hold[i] <= '0;
      end
      else
      begin
         phase <= ~phase;
         grant <= grant_nxt;      // Aligned with the registered bus

         // Lockout runs 1..HOLD then clears, reloaded on grant
         for (int i = 0; i < `VS_NUM_REQ; i++)
         begin
            if (hold[i] == HOLD_W'(`VS_HOLD_CYCLES))
               hold[i] <= '0;
            else if (hold[i] != '0)
               hold[i] <= hold[i] + 1'b1;
            if (grant_nxt[i])
               hold[i] <= HOLD_W'(1);
         end

         tag.vid    <= ~phase;
         tag.x_lsb  <= pix_x[0];
         tag.req_id <= sel_id;
         tag.rd     <= (|grant_nxt) && !sel_req.write;

         // Default is a read, both bytes, bus released
         sram.we_n  <= 1'b1;
         sram.lb_n  <= 1'b0;
         sram.ub_n  <= 1'b0;
         sram.dq_oe <= 1'b0;
         if (!phase)
            sram.addr <= {pix_y[8:0], pix_x[9:1]};   // Row above word column
         else if (|grant_nxt)
         begin
            sram.addr <= sel_req.addr;
            if (sel_req.write)
            begin
               sram.we_n   <= 1'b0;
               sram.dq_oe  <= 1'b1;
               sram.dq_out <= sel_req.wdata;
               sram.lb_n   <= sel_req.byte_hi;       // Mask the other byte
               sram.ub_n   <= ~sel_req.byte_hi;
            end
         end
         // Idle processor cycle keeps the last address
      end
   end

   // Never two requesters on the bus at once
   a_grant_onehot: assert property (@(posedge clk) disable iff (!reset)
      $onehot0(grant));

   // Writes only come out of a processor setup
   a_write_phase: assert property (@(posedge clk) disable iff (!reset)
      !sram.we_n |-> $past(phase));

endmodule

/* hdl/vga_sram_pkg.sv */
// Shared types for the video SRAM path
// Requester request, SRAM bus, pixel index, SRAM word views, capture tag

`include "vga_sram_cfg.svh"

package vga_sram_pkg;

   // One processor requester, req held until granted
   typedef struct packed {
      logic                  req;      // Request level
      logic                  write;    // 1 = write
      logic                  byte_hi;  // Write upper byte, else lower
      logic [`VS_ADDR_W-1:0] addr;
      logic [`VS_DATA_W-1:0] wdata;
   } sram_req_t;

   // Registered SRAM pins, data bus split in/out
   typedef struct packed {
      logic [`VS_ADDR_W-1:0] addr;
      logic                  we_n;     // Write strobe
      logic                  lb_n;     // Lower byte enable
      logic                  ub_n;     // Upper byte enable
      logic                  dq_oe;    // Drive dq_out onto the bus
      logic [`VS_DATA_W-1:0] dq_out;
   } sram_bus_t;

   // One 8-bit pixel index
   typedef struct packed {
      logic [1:0] level;   // Brightness, 3 = full
      logic [1:0] red;
      logic [1:0] green;
      logic [1:0] blue;
   } color_index_t;

   typedef struct packed {
      color_index_t hi;    // Odd x
      color_index_t lo;    // Even x
   } pixel_pair_t;

   // Requesters see raw data, video sees two pixels
   typedef union packed {
      logic [`VS_DATA_W-1:0] raw;
      pixel_pair_t           pix;
   } sram_word_u;

   // Stage 1 setup, consumed by stage 2 one cycle later
   typedef struct packed {
      logic       vid;     // Video read set up
      logic       x_lsb;   // Pixel within the word
      logic [1:0] req_id;  // Granted requester
      logic       rd;      // Requester read set up
   } cap_tag_t;

endpackage

/* include/vga_sram_cfg.svh */
// Video SRAM path configuration
// Bus widths, requester count, hold interval, colour ramp

`ifndef VGA_SRAM_CFG_SVH
`define VGA_SRAM_CFG_SVH

// SRAM geometry
`define VS_ADDR_W       18     // Word address
`define VS_DATA_W       16     // Two pixel indices per word

// Video side
`define VS_COORD_W      10     // Pixel x and y
`define VS_RGB_W        10     // Per colour component

// Processor side
`define VS_NUM_REQ      3      // Fixed priority, lowest index wins
`define VS_HOLD_CYCLES  10     // Lockout after each grant

// Full-brightness ramp, indexed by 2-bit colour field
`define VS_RAMP_0       0
`define VS_RAMP_1       256
`define VS_RAMP_2       512
`define VS_RAMP_3       1023

`endif
